// File: uart_pkg.sv
// uart constants for frame format, oversampling, baud divisor and the host status struct
`default_nettype none

package uart_pkg;

   // frame format is fixed at 8N1
   localparam int data_bits = 8;

   // fifo depth is 2**fifo_addr_bits
   localparam int fifo_addr_bits = 4;

   localparam int os_ticks = 16;   // sample ticks per bit period

   // clocks per sample tick, so one bit is os_ticks*baud_dvsr clocks
   localparam int baud_dvsr     = 4;
   localparam int baud_cnt_bits = $clog2(baud_dvsr);

   // flags the host polls
   typedef struct packed {
      logic rx_empty;   // no received byte waiting
      logic tx_full;    // further host writes are dropped
   } uart_status_t;

endpackage

`default_nettype wire

// File: fifo.sv
// fifo module: register array with read and write pointers and registered full/empty flags
`timescale 1ns/1ps
`default_nettype none

module fifo
#(
   parameter int data_width = 8,   // bits per word
   parameter int addr_bits  = 4    // depth is 2**addr_bits
)
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   rd,
   input  wire                   wr,
   input  wire  [data_width-1:0] w_data,
   output logic                  empty,
   output logic                  full,
   output logic [data_width-1:0] r_data
);

   logic [data_width-1:0] array_reg [2**addr_bits];
   logic [addr_bits-1:0]  w_ptr_reg, w_ptr_next, w_ptr_succ;
   logic [addr_bits-1:0]  r_ptr_reg, r_ptr_next, r_ptr_succ;
   logic                  full_reg, full_next;
   logic                  empty_reg, empty_next;
   logic                  wr_en;

   // full blocks a write unless a pop frees the slot in the same cycle
   assign wr_en = wr & (~full_reg | rd);

   always_ff @(posedge clk)
      if (wr_en)
         array_reg[w_ptr_reg] <= w_data;

   assign r_data = array_reg[r_ptr_reg];   // head visible while not empty

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         w_ptr_reg <= '0;
         r_ptr_reg <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
      end
      else
      begin
         w_ptr_reg <= w_ptr_next;
         r_ptr_reg <= r_ptr_next;
         full_reg  <= full_next;
         empty_reg <= empty_next;
      end

   always_comb
   begin
      w_ptr_succ = w_ptr_reg + 1'b1;
      r_ptr_succ = r_ptr_reg + 1'b1;
      w_ptr_next = w_ptr_reg;
      r_ptr_next = r_ptr_reg;
      full_next  = full_reg;
      empty_next = empty_reg;
      case ({wr, rd})
         2'b01:   // pop
            if (!empty_reg)
            begin
               r_ptr_next = r_ptr_succ;
               full_next  = 1'b0;
               if (r_ptr_succ == w_ptr_reg)
                  empty_next = 1'b1;
            end
         2'b10:   // push
            if (!full_reg)
            begin
               w_ptr_next = w_ptr_succ;
               empty_next = 1'b0;
               if (w_ptr_succ == r_ptr_reg)
                  full_next = 1'b1;
            end
         2'b11:
            if (empty_reg)   // nothing to pop yet, push only
            begin
               w_ptr_next = w_ptr_succ;
               empty_next = 1'b0;
               if (w_ptr_succ == r_ptr_reg)
                  full_next = 1'b1;
            end
            else   // occupancy unchanged
            begin
               w_ptr_next = w_ptr_succ;
               r_ptr_next = r_ptr_succ;
            end
         default: ;
      endcase
   end

   assign full  = full_reg;
   assign empty = empty_reg;

endmodule

`default_nettype wire

// File: baud_gen.sv
// baud_gen module: modulo counter giving one sample tick per oversampling period
`timescale 1ns/1ps
`default_nettype none

module baud_gen
(
   input  wire  clk,
   input  wire  reset,
   output logic tick
);

   typedef logic [uart_pkg::baud_cnt_bits-1:0] cnt_t;

   cnt_t cnt_reg;

   // high on the last count of each period
   assign tick = (cnt_reg == cnt_t'(uart_pkg::baud_dvsr - 1));

   always_ff @(posedge clk, posedge reset)
      if (reset)
         cnt_reg <= '0;
      else if (tick)
         cnt_reg <= '0;   // wrap
      else
         cnt_reg <= cnt_reg + 1'b1;

endmodule

`default_nettype wire

// File: uart_rx.sv
// uart_rx module: rx synchronizer, start-bit detection and oversampled 8N1 capture
`timescale 1ns/1ps
`default_nettype none

module uart_rx
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            rx,
   input  wire                            tick,
   output logic                           rx_done_tick,
   output logic [uart_pkg::data_bits-1:0] dout
);

   typedef enum logic [1:0] {idle, start, data, stop} state_t;
   typedef logic [$clog2(uart_pkg::os_ticks)-1:0]  tick_cnt_t;
   typedef logic [$clog2(uart_pkg::data_bits)-1:0] bit_cnt_t;

   state_t                         state_reg, state_next;
   tick_cnt_t                      s_reg, s_next;   // ticks within the bit
   bit_cnt_t                       n_reg, n_next;   // data bits taken
   logic [uart_pkg::data_bits-1:0] b_reg, b_next;
   logic [2:0]                     rx_sync;   // two sync stages plus edge history
   logic                           rx_s;
   logic                           rx_fall;
   logic                           done_next;

   assign rx_s    = rx_sync[1];
   assign rx_fall = rx_sync[2] & ~rx_sync[1];

   always_ff @(posedge clk, posedge reset)
      if (reset)
         rx_sync <= '1;   // line idles high
      else
         rx_sync <= {rx_sync[1:0], rx};

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         state_reg    <= idle;
         s_reg        <= '0;
         n_reg        <= '0;
         rx_done_tick <= 1'b0;
      end
      else
      begin
         state_reg    <= state_next;
         s_reg        <= s_next;
         n_reg        <= n_next;
         rx_done_tick <= done_next;
      end

   always_ff @(posedge clk)
      b_reg <= b_next;

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      done_next  = 1'b0;
      case (state_reg)
         idle:
            if (rx_fall)
            begin
               state_next = start;
               s_next     = '0;
            end
         start:   // wait to the middle of the start bit
            if (tick)
            begin
               if (s_reg == tick_cnt_t'(uart_pkg::os_ticks / 2 - 1))
               begin
                  s_next     = '0;
                  n_next     = '0;
                  state_next = rx_s ? idle : data;   // high again means a glitch
               end
               else
                  s_next = s_reg + 1'b1;
            end
         data:
            if (tick)
            begin
               if (s_reg == tick_cnt_t'(uart_pkg::os_ticks - 1))
               begin
                  s_next = '0;
                  b_next = {rx_s, b_reg[uart_pkg::data_bits-1:1]};   // lsb arrives first
                  if (n_reg == bit_cnt_t'(uart_pkg::data_bits - 1))
                     state_next = stop;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         stop:
            if (tick)
            begin
               if (s_reg == tick_cnt_t'(uart_pkg::os_ticks - 1))
               begin
                  state_next = idle;   // mid stop bit
                  done_next  = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         default:
            state_next = idle;
      endcase
   end

   assign dout = b_reg;

endmodule

`default_nettype wire

// File: uart_tx.sv
// uart_tx module: fifo-fed 8N1 transmitter shifting data out lsb first
`timescale 1ns/1ps
`default_nettype none

module uart_tx
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            tick,
   input  wire                            tx_avail,
   input  wire  [uart_pkg::data_bits-1:0] din,
   output logic                           tx_pop,
   output logic                           tx
);

   typedef enum logic [1:0] {idle, start, data, stop} state_t;
   typedef logic [$clog2(uart_pkg::os_ticks)-1:0]  tick_cnt_t;
   typedef logic [$clog2(uart_pkg::data_bits)-1:0] bit_cnt_t;

   state_t                         state_reg, state_next;
   tick_cnt_t                      s_reg, s_next;
   bit_cnt_t                       n_reg, n_next;
   logic [uart_pkg::data_bits-1:0] b_reg, b_next;   // byte being shifted out
   logic                           tx_reg, tx_next;
   logic                           bit_end;

   // leave idle only on a tick so the start bit is a whole bit period
   assign tx_pop  = (state_reg == idle) & tx_avail & tick;
   assign bit_end = tick & (s_reg == tick_cnt_t'(uart_pkg::os_ticks - 1));

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;   // line idles high
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end

   always_ff @(posedge clk)
      b_reg <= b_next;

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      if (state_reg == idle)
      begin
         if (tx_pop)
         begin
            b_next     = din;   // fifo head, popped this cycle
            s_next     = '0;
            state_next = start;
         end
      end
      else if (bit_end)
      begin
         s_next = '0;
         case (state_reg)
            start:
            begin
               n_next     = '0;
               state_next = data;
            end
            data:
            begin
               b_next = b_reg >> 1;
               if (n_reg == bit_cnt_t'(uart_pkg::data_bits - 1))
                  state_next = stop;
               else
                  n_next = n_reg + 1'b1;
            end
            default:
               state_next = idle;   // end of stop bit
         endcase
      end
      else if (tick)
         s_next = s_reg + 1'b1;

      // line level for the coming cycle
      case (state_next)
         start:   tx_next = 1'b0;
         data:    tx_next = b_next[0];
         default: tx_next = 1'b1;
      endcase
   end

   assign tx = tx_reg;

endmodule

`default_nettype wire

// File: uart.sv
// uart top level: baud tick, receiver, transmitter and the rx/tx fifos
`timescale 1ns/1ps
`default_nettype none

module uart
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            rd_uart,
   input  wire                            wr_uart,
   input  wire  [uart_pkg::data_bits-1:0] w_data,
   output logic [uart_pkg::data_bits-1:0] r_data,
   output uart_pkg::uart_status_t         status,
   input  wire                            rx,
   output logic                           tx
);

   logic                           tick;
   logic                           rx_done_tick;
   logic [uart_pkg::data_bits-1:0] rx_dout;
   logic [uart_pkg::data_bits-1:0] tx_din;   // tx fifo head
   logic                           rx_empty;
   logic                           tx_empty;
   logic                           tx_full;
   logic                           tx_pop;
   logic                           tx_avail;

   assign tx_avail = ~tx_empty;
   assign status   = '{rx_empty: rx_empty, tx_full: tx_full};

   baud_gen baud_gen_i (.clk(clk), .reset(reset), .tick(tick));

   uart_rx uart_rx_i
   (
      .clk(clk), .reset(reset), .rx(rx), .tick(tick),
      .rx_done_tick(rx_done_tick), .dout(rx_dout)
   );

   // received bytes are dropped once this is full
   fifo #(.data_width(uart_pkg::data_bits), .addr_bits(uart_pkg::fifo_addr_bits)) fifo_rx
   (
      .clk(clk), .reset(reset), .rd(rd_uart), .wr(rx_done_tick), .w_data(rx_dout),
      .empty(rx_empty), .full(), .r_data(r_data)
   );

   fifo #(.data_width(uart_pkg::data_bits), .addr_bits(uart_pkg::fifo_addr_bits)) fifo_tx
   (
      .clk(clk), .reset(reset), .rd(tx_pop), .wr(wr_uart), .w_data(w_data),
      .empty(tx_empty), .full(tx_full), .r_data(tx_din)
   );

   uart_tx uart_tx_i
   (
      .clk(clk), .reset(reset), .tick(tick), .tx_avail(tx_avail),
      .din(tx_din), .tx_pop(tx_pop), .tx(tx)
   );

endmodule

`default_nettype wire

// File: tb_uart.sv
// tb_uart testbench: serial driver and monitor, lfsr stimulus and assertion checks
`timescale 1ns/1ps
`default_nettype none

module tb_uart;

   typedef logic [uart_pkg::data_bits-1:0] byte_t;

   localparam int clk_period   = 4;
   localparam int bit_clks     = uart_pkg::os_ticks * uart_pkg::baud_dvsr;
   localparam int frame_clks   = 10 * bit_clks;
   localparam int total_frames = 3 + 1 + 17 + 20 + 16;   // frames over all tests

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   rd_uart;
   logic                   wr_uart;
   logic                   rx;
   byte_t                  w_data;
   byte_t                  r_data;
   uart_pkg::uart_status_t status;
   wire                    tx;

   byte_t      tx_exp[$];   // accepted host writes with the oldest first
   byte_t      rx_exp[$];
   logic [7:0] lfsr_state = 8'd7;
   logic       saw_full;
   int         errors = 0;
   int         passed = 0;
   int         failed = 0;

   uart uart_i
   (
      .clk(clk), .reset(reset), .rd_uart(rd_uart), .wr_uart(wr_uart), .w_data(w_data),
      .r_data(r_data), .status(status), .rx(rx), .tx(tx)
   );

   always #(clk_period / 2) clk = ~clk;

   // galois form of x^8+x^6+x^5+x^4+1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
   endfunction

   function automatic byte_t next_byte();
      byte_t b;
      for (int i = 0; i < uart_pkg::data_bits; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);   // one step per bit
         b[i]       = lfsr_state[0];
      end
      return b;
   endfunction

   task automatic report_error(input string msg);
      $display("Error at time %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before)
      begin
         $display("test %s: ok", name);
         passed++;
      end
      else
      begin
         $display("test %s: failed", name);
         failed++;
      end
   endtask

   // one 8N1 frame on rx with lsb first
   task automatic send_frame(input byte_t b);
      @(negedge clk);
      rx = 1'b0;
      repeat (bit_clks) @(negedge clk);
      for (int i = 0; i < uart_pkg::data_bits; i++)
      begin
         rx = b[i];
         repeat (bit_clks) @(negedge clk);
      end
      rx = 1'b1;   // stop bit
      repeat (bit_clks) @(negedge clk);
   endtask

   // every clock of the frame is sampled and each bit value is taken mid-bit
   task automatic recv_frame(output byte_t b, output logic stop_bit);
      logic       first;
      logic       steady;
      logic [9:0] frame;
      steady = 1'b1;
      @(negedge tx);
      for (int k = 0; k < 10; k++)
      begin
         for (int j = 0; j < bit_clks; j++)
         begin
            @(negedge clk);
            if (j == 0)
               first = tx;
            else if (tx !== first)
               steady = 1'b0;   // edge inside a bit period
            if (j == bit_clks / 2)
               frame[k] = tx;
         end
      end
      assert (steady) else report_error("tx changed within a bit period");
      assert (frame[0] == 1'b0) else report_error("start bit not low at mid-bit");
      b        = frame[8:1];
      stop_bit = frame[9];
   endtask

   // frames on tx against accepted writes until none are left
   task automatic drain_tx();
      byte_t b;
      logic  stop_bit;
      do
      begin
         recv_frame(b, stop_bit);
         assert (stop_bit == 1'b1) else report_error("stop bit not high");
         if (tx_exp.size() == 0)
            report_error("frame on tx without an accepted write");
         else
         begin
            assert (b == tx_exp[0])
               else report_error($sformatf("tx byte %h, expected %h", b, tx_exp[0]));
            void'(tx_exp.pop_front());
         end
      end
      while (tx_exp.size() != 0);
   endtask

   // a write counts when tx_full is low at its edge
   task automatic write_burst(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         wr_uart = 1'b1;
         w_data  = next_byte();
         if (status.tx_full)
            saw_full = 1'b1;
         else
            tx_exp.push_back(w_data);
      end
      @(negedge clk);
      wr_uart = 1'b0;
   endtask

   task automatic read_byte(output byte_t b);
      int t;
      t = 0;
      while (status.rx_empty && t < 2 * frame_clks)
      begin
         @(negedge clk);
         t++;
      end
      assert (!status.rx_empty) else report_error("no received byte within two frame times");
      b       = r_data;   // head is visible before the pop
      rd_uart = 1'b1;
      @(negedge clk);
      rd_uart = 1'b0;
   endtask

   task automatic check_rx(input int n);
      byte_t b;
      repeat (n)
      begin
         read_byte(b);
         assert (b == rx_exp[0])
            else report_error($sformatf("rx byte %h, expected %h", b, rx_exp[0]));
         void'(rx_exp.pop_front());
      end
   endtask

   // watchdog at twice the frame time of all tests
   initial
   begin
      #(2 * total_frames * frame_clks * clk_period);
      $display("timeout: the tests did not finish in the expected time");
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      int    e;
      byte_t b;
      reset    = 1'b1;
      rd_uart  = 1'b0;
      wr_uart  = 1'b0;
      w_data   = '0;
      rx       = 1'b1;
      saw_full = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      e = errors;
      repeat (8)
      begin
         assert (tx == 1'b1 && status.rx_empty && !status.tx_full)
            else report_error("idle outputs wrong after reset");
         @(negedge clk);
      end
      report_test("reset state", e);

      e = errors;
      fork
         write_burst(3);
         drain_tx();
      join
      assert (!saw_full) else report_error("tx_full high during a short burst");
      report_test("transmit framing", e);

      e = errors;
      b = next_byte();
      rx_exp.push_back(b);
      send_frame(b);
      check_rx(1);
      assert (status.rx_empty) else report_error("rx_empty not high after the pop");
      report_test("receive path", e);

      e = errors;
      repeat (17)
      begin
         b = next_byte();
         if (rx_exp.size() < 16)
            rx_exp.push_back(b);   // 17th is dropped by the full fifo
         send_frame(b);
      end
      assert (!status.rx_empty) else report_error("rx_empty high with bytes waiting");
      check_rx(16);
      assert (status.rx_empty) else report_error("rx_empty not high after 16 reads");
      report_test("receive overflow", e);

      e = errors;
      saw_full = 1'b0;
      fork
         write_burst(20);
         drain_tx();
      join
      assert (saw_full) else report_error("tx_full never high during the burst");
      report_test("transmit back-pressure", e);

      e = errors;
      saw_full = 1'b0;
      repeat (8) rx_exp.push_back(next_byte());
      fork
         write_burst(8);
         drain_tx();
         begin
            foreach (rx_exp[i])
               send_frame(rx_exp[i]);
            check_rx(8);
         end
      join
      assert (!saw_full) else report_error("tx_full high during the duplex burst");
      report_test("full duplex", e);

      $display("tests passed: %0d, failed: %0d", passed, failed);
      if (failed == 0 && errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
uart_pkg.sv
fifo.sv
baud_gen.sv
uart_rx.sv
uart_tx.sv
uart.sv
tb_uart.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_uart
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
